//--- logic/uart_mmio_pkg.sv
package uart_mmio_pkg;

  // UART timing
  localparam int CLOCK_FREQ   = 1_152_000;
  localparam int BAUD_RATE    = 115_200;
  localparam int CLKS_PER_BIT = CLOCK_FREQ / BAUD_RATE;  // 10 clocks per bit
  localparam int TIMER_WIDTH  = $clog2(CLKS_PER_BIT);

  // Bus and buffer sizes
  localparam int AXIL_AWIDTH   = 8;
  localparam int AXIL_DWIDTH   = 32;
  localparam int FIFO_LOGDEPTH = 5;  // 32 bytes per FIFO

  // Register map, byte offsets
  localparam logic [AXIL_AWIDTH-1:0] REG_STATUS  = 8'h00;  // {rx_valid, tx_ready}
  localparam logic [AXIL_AWIDTH-1:0] REG_RX_DATA = 8'h04;  // Read pops the head
  localparam logic [AXIL_AWIDTH-1:0] REG_TX_DATA = 8'h08;
  localparam logic [AXIL_AWIDTH-1:0] REG_CYCLES  = 8'h10;
  localparam logic [AXIL_AWIDTH-1:0] REG_CNT_RST = 8'h18;  // Any write clears

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  typedef logic [7:0] uart_byte_t;

  // One byte stream, ready travels back on its own wire
  typedef struct packed {
    logic       valid;
    uart_byte_t data;
  } byte_stream_t;

  // Master side of AXI4-Lite
  typedef struct packed {
    logic                       awvalid;
    logic [AXIL_AWIDTH-1:0]     awaddr;
    logic                       wvalid;
    logic [AXIL_DWIDTH-1:0]     wdata;
    logic [AXIL_DWIDTH/8-1:0]   wstrb;
    logic                       bready;
    logic                       arvalid;
    logic [AXIL_AWIDTH-1:0]     araddr;
    logic                       rready;
  } axil_req_t;

  // Slave side of AXI4-Lite
  typedef struct packed {
    logic                   awready;
    logic                   wready;
    logic                   bvalid;
    logic [1:0]             bresp;
    logic                   arready;
    logic                   rvalid;
    logic [AXIL_DWIDTH-1:0] rdata;
    logic [1:0]             rresp;
  } axil_rsp_t;

endpackage

//--- logic/uart_bit_timer.sv
module uart_bit_timer (
  input  logic clk,
  input  logic rst_n,
  input  logic start,
  output logic bit_tick,
  output logic mid_tick
);
  import uart_mmio_pkg::*;

  logic [TIMER_WIDTH-1:0] cnt;

  // Owner holds start high for the whole frame
  // Dropping it parks the count at zero
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt <= '0;
    end else if (!start || bit_tick) begin
      cnt <= '0;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  // Last clock of each bit period
  assign bit_tick = start && (cnt == TIMER_WIDTH'(CLKS_PER_BIT - 1));

  // Centre of the bit, used for sampling
  assign mid_tick = start && (cnt == TIMER_WIDTH'(CLKS_PER_BIT / 2));

endmodule

//--- logic/byte_fifo.sv
module byte_fifo (
  input  logic                        clk,
  input  logic                        rst_n,
  input  uart_mmio_pkg::byte_stream_t enq,
  output logic                        enq_ready,
  output uart_mmio_pkg::byte_stream_t deq,
  input  logic                        deq_ready
);
  import uart_mmio_pkg::*;

  uart_byte_t               mem [2**FIFO_LOGDEPTH];
  logic [FIFO_LOGDEPTH-1:0] wr_ptr;
  logic [FIFO_LOGDEPTH-1:0] rd_ptr;
  logic [FIFO_LOGDEPTH:0]   count;  // 0 to 32 entries
  logic                     do_enq;
  logic                     do_deq;

  // MSB of count is set only when all 32 entries hold data
  assign enq_ready = !count[FIFO_LOGDEPTH];

  // Fall-through head
  assign deq = '{valid: (count != '0), data: mem[rd_ptr]};

  assign do_enq = enq.valid && enq_ready;
  assign do_deq = deq.valid && deq_ready;

  always_ff @(posedge clk) begin
    if (do_enq) mem[wr_ptr] <= enq.data;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_enq) wr_ptr <= wr_ptr + 1'b1;  // Wraps at 32
      if (do_deq) rd_ptr <= rd_ptr + 1'b1;
      case ({do_enq, do_deq})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Both or neither
      endcase
    end
  end

endmodule

//--- logic/uart_tx.sv
module uart_tx (
  input  logic                        clk,
  input  logic                        rst_n,
  input  uart_mmio_pkg::byte_stream_t data_in,
  output logic                        data_in_ready,
  output logic                        serial_out
);
  import uart_mmio_pkg::*;

  logic       busy;
  logic [9:0] frame_q;  // {stop, data[7:0], start}
  logic [3:0] bit_idx;
  logic       accept;
  logic       bit_tick;

  uart_bit_timer u_timer (
    .clk      (clk),
    .rst_n    (rst_n),
    .start    (busy),
    .bit_tick (bit_tick),
    .mid_tick ()
  );

  // New byte only between frames
  assign data_in_ready = !busy;
  assign accept        = data_in.valid && !busy;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy    <= 1'b0;
      bit_idx <= '0;
    end else if (accept) begin
      busy    <= 1'b1;
      bit_idx <= '0;
    end else if (bit_tick) begin
      if (bit_idx == 4'd9) begin
        busy <= 1'b0;  // Stop bit done
      end else begin
        bit_idx <= bit_idx + 4'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      frame_q <= {1'b1, data_in.data, 1'b0};
    end else if (bit_tick) begin
      frame_q <= {1'b1, frame_q[9:1]};  // LSB first
    end
  end

  // Line idles high
  assign serial_out = busy ? frame_q[0] : 1'b1;

endmodule

//--- logic/uart_rx.sv
module uart_rx (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        serial_in,
  output uart_mmio_pkg::byte_stream_t data_out,
  input  logic                        data_out_ready
);
  import uart_mmio_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    START,
    DATA,
    STOP
  } state_t;

  state_t     state;
  logic [2:0] sync_q;  // Two sync stages plus edge history
  logic       rx_bit;
  logic       fall_edge;
  logic       mid_tick;
  logic [2:0] bit_idx;
  uart_byte_t shift_q;
  logic       valid_q;
  logic       held_q;  // Byte already waited one cycle

  uart_bit_timer u_timer (
    .clk      (clk),
    .rst_n    (rst_n),
    .start    (state != IDLE),
    .bit_tick (),
    .mid_tick (mid_tick)
  );

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sync_q <= '1;
    end else begin
      sync_q <= {sync_q[1:0], serial_in};
    end
  end

  assign rx_bit    = sync_q[1];
  assign fall_edge = sync_q[2] && !sync_q[1];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= IDLE;
      bit_idx <= '0;
    end else begin
      case (state)
        IDLE:  if (fall_edge) state <= START;
        START: if (mid_tick) state <= rx_bit ? IDLE : DATA;  // Glitch if line is high again
        DATA: begin
          if (mid_tick) begin
            bit_idx <= bit_idx + 3'd1;  // Wraps back to 0 after bit 7
            if (bit_idx == 3'd7) state <= STOP;
          end
        end
        STOP:  if (mid_tick) state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == DATA && mid_tick) shift_q <= {rx_bit, shift_q[7:1]};
  end

  // Byte shows up the cycle after the stop bit centre
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
      held_q  <= 1'b0;
    end else if (state == STOP && mid_tick) begin
      valid_q <= 1'b1;
      held_q  <= 1'b0;
    end else if (valid_q) begin
      if (data_out_ready || held_q) begin
        valid_q <= 1'b0;  // Taken, or lost to a full FIFO
        held_q  <= 1'b0;
      end else begin
        held_q <= 1'b1;
      end
    end
  end

  assign data_out = '{valid: valid_q, data: shift_q};

endmodule

//--- logic/axil_mmio_fsm.sv
module axil_mmio_fsm (
  input  logic                        clk,
  input  logic                        rst_n,
  input  uart_mmio_pkg::axil_req_t    axil_req,
  output uart_mmio_pkg::axil_rsp_t    axil_rsp,
  output uart_mmio_pkg::byte_stream_t tx_push,
  input  logic                        tx_push_ready,
  input  uart_mmio_pkg::byte_stream_t rx_head,
  output logic                        rx_pop
);
  import uart_mmio_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    ACCEPT,  // Readies high for exactly one cycle
    WRESP,
    RDATA
  } state_t;

  state_t                 state;
  logic                   wr_op;  // Transaction in flight is a write
  logic [AXIL_AWIDTH-1:0] addr_q;
  logic [1:0]             bresp_q;
  logic [1:0]             rresp_q;
  logic [AXIL_DWIDTH-1:0] rdata_q;
  logic [AXIL_DWIDTH-1:0] cycle_cnt;

  logic                   accept_wr;
  logic                   accept_rd;
  logic                   wr_legal;
  logic                   cnt_clear;
  logic [AXIL_DWIDTH-1:0] rd_word;
  logic [1:0]             rd_resp;

  assign accept_wr = (state == ACCEPT) && wr_op;
  assign accept_rd = (state == ACCEPT) && !wr_op;

  // Only the TX data and counter reset offsets take writes
  assign wr_legal  = (addr_q == REG_TX_DATA) || (addr_q == REG_CNT_RST);
  assign cnt_clear = accept_wr && (addr_q == REG_CNT_RST);

  // Push is dropped by the FIFO when full, response stays OKAY
  assign tx_push = '{valid: accept_wr && (addr_q == REG_TX_DATA) && axil_req.wstrb[0],
                     data:  axil_req.wdata[7:0]};

  assign rx_pop = accept_rd && (addr_q == REG_RX_DATA) && rx_head.valid;

  always_comb begin
    rd_word = '0;
    rd_resp = RESP_OKAY;
    case (addr_q)
      REG_STATUS:  rd_word = {{(AXIL_DWIDTH-2){1'b0}}, rx_head.valid, tx_push_ready};
      REG_RX_DATA: begin
        if (rx_head.valid) begin
          rd_word = {{(AXIL_DWIDTH-8){1'b0}}, rx_head.data};
        end
      end
      REG_CYCLES:  rd_word = cycle_cnt;
      default:     rd_resp = RESP_SLVERR;  // Unmapped or write-only
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= IDLE;
      wr_op <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (axil_req.awvalid && axil_req.wvalid) begin  // Write wins a tie
            wr_op <= 1'b1;
            state <= ACCEPT;
          end else if (axil_req.arvalid) begin
            wr_op <= 1'b0;
            state <= ACCEPT;
          end
        end
        ACCEPT:  state <= wr_op ? WRESP : RDATA;
        WRESP:   if (axil_req.bready) state <= IDLE;
        RDATA:   if (axil_req.rready) state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == IDLE) begin
      addr_q <= (axil_req.awvalid && axil_req.wvalid) ? axil_req.awaddr : axil_req.araddr;
    end
    if (accept_wr) bresp_q <= wr_legal ? RESP_OKAY : RESP_SLVERR;
    if (accept_rd) begin
      rdata_q <= rd_word;
      rresp_q <= rd_resp;
    end
  end

  // Free-running cycle counter
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cycle_cnt <= '0;
    end else if (cnt_clear) begin
      cycle_cnt <= '0;
    end else begin
      cycle_cnt <= cycle_cnt + 1'b1;
    end
  end

  always_comb begin
    axil_rsp.awready = accept_wr;
    axil_rsp.wready  = accept_wr;
    axil_rsp.bvalid  = (state == WRESP);
    axil_rsp.bresp   = bresp_q;
    axil_rsp.arready = accept_rd;
    axil_rsp.rvalid  = (state == RDATA);
    axil_rsp.rdata   = rdata_q;
    axil_rsp.rresp   = rresp_q;
  end

endmodule

//--- logic/uart_mmio_top.sv
module uart_mmio_top (
  input  logic                     clk,
  input  logic                     rst_n,
  input  uart_mmio_pkg::axil_req_t axil_req,
  output uart_mmio_pkg::axil_rsp_t axil_rsp,
  input  logic                     serial_rx,
  output logic                     serial_tx
);
  import uart_mmio_pkg::*;

  // Slave to TX FIFO
  byte_stream_t tx_push;
  logic         tx_push_ready;

  // TX FIFO to serializer
  byte_stream_t tx_byte;
  logic         tx_byte_ready;

  // Deserializer to RX FIFO
  byte_stream_t rx_byte;
  logic         rx_byte_ready;

  // RX FIFO head seen by the slave
  byte_stream_t rx_head;
  logic         rx_pop;

  axil_mmio_fsm u_fsm (
    .clk           (clk),
    .rst_n         (rst_n),
    .axil_req      (axil_req),
    .axil_rsp      (axil_rsp),
    .tx_push       (tx_push),
    .tx_push_ready (tx_push_ready),
    .rx_head       (rx_head),
    .rx_pop        (rx_pop)
  );

  byte_fifo u_tx_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .enq       (tx_push),
    .enq_ready (tx_push_ready),
    .deq       (tx_byte),
    .deq_ready (tx_byte_ready)
  );

  uart_tx u_uart_tx (
    .clk           (clk),
    .rst_n         (rst_n),
    .data_in       (tx_byte),
    .data_in_ready (tx_byte_ready),
    .serial_out    (serial_tx)
  );

  uart_rx u_uart_rx (
    .clk            (clk),
    .rst_n          (rst_n),
    .serial_in      (serial_rx),
    .data_out       (rx_byte),
    .data_out_ready (rx_byte_ready)
  );

  byte_fifo u_rx_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .enq       (rx_byte),
    .enq_ready (rx_byte_ready),
    .deq       (rx_head),
    .deq_ready (rx_pop)
  );

endmodule

//--- verif/uart_mmio_chk.sv
module uart_mmio_chk (
  input logic                        clk,
  input logic                        rst_n,
  input uart_mmio_pkg::axil_req_t    axil_req,
  input uart_mmio_pkg::axil_rsp_t    axil_rsp,
  input logic                        tx_push_ready,
  input uart_mmio_pkg::byte_stream_t tx_byte,
  input logic                        tx_byte_ready,
  input logic                        serial_tx
);

  int unsigned fail_cnt = 0;  // Read by the testbench at the end

  bresp_hold: assert property (@(posedge clk) disable iff (!rst_n)
    axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid && $stable(axil_rsp.bresp))
  else begin
    $error("bvalid or bresp changed before bready");
    fail_cnt++;
  end

  rdata_hold: assert property (@(posedge clk) disable iff (!rst_n)
    axil_rsp.rvalid && !axil_req.rready |=>
      axil_rsp.rvalid && $stable(axil_rsp.rdata) && $stable(axil_rsp.rresp))
  else begin
    $error("rvalid, rdata or rresp changed before rready");
    fail_cnt++;
  end

  // First clock out of reset
  quiet_after_reset: assert property (@(posedge clk)
    $rose(rst_n) |-> !(axil_rsp.awready || axil_rsp.wready || axil_rsp.bvalid ||
                       axil_rsp.arready || axil_rsp.rvalid))
  else begin
    $error("AXI valid or ready high in the first cycle after reset");
    fail_cnt++;
  end

  // One drain from a full FIFO frees a slot only if nothing slipped in while full
  tx_fifo_no_overfill: assert property (@(posedge clk) disable iff (!rst_n)
    !tx_push_ready && tx_byte.valid && tx_byte_ready |=> tx_push_ready)
  else begin
    $error("TX FIFO took a byte while full");
    fail_cnt++;
  end

  tx_idle_high: assert property (@(posedge clk) disable iff (!rst_n)
    tx_byte_ready |-> serial_tx)
  else begin
    $error("serial_tx low while the transmitter is idle");
    fail_cnt++;
  end

endmodule

bind uart_mmio_top uart_mmio_chk u_chk (
  .clk           (clk),
  .rst_n         (rst_n),
  .axil_req      (axil_req),
  .axil_rsp      (axil_rsp),
  .tx_push_ready (tx_push_ready),
  .tx_byte       (tx_byte),
  .tx_byte_ready (tx_byte_ready),
  .serial_tx     (serial_tx)
);

//--- verif/tb_uart_mmio.sv
module tb_uart_mmio;
  import uart_mmio_pkg::*;

  localparam int HANDSHAKE_LIMIT = 32;   // Clocks per AXI channel
  localparam int POLL_LIMIT      = 100;  // Status reads per loop-back byte
  localparam int IDLE_GAP        = 50;
  localparam int FILL_WRITES     = 36;   // Fills the TX FIFO and overflows by two

  typedef struct packed {
    uart_byte_t send;
    uart_byte_t expect_rx;
  } loop_vec_t;

  localparam loop_vec_t LOOP_TABLE [8] = '{
    '{8'h55, 8'h55},
    '{8'hA5, 8'hA5},
    '{8'h00, 8'h00},
    '{8'hFF, 8'hFF},
    '{8'h01, 8'h01},
    '{8'h80, 8'h80},
    '{8'h3C, 8'h3C},
    '{8'hC3, 8'hC3}
  };

  logic       clk;
  logic       rst_n;
  axil_req_t  axil_req;
  axil_rsp_t  axil_rsp;
  logic       serial_line;  // External loop-back wire
  int         errors;
  int         checks;
  uart_byte_t decoded_q [$];
  event       abort_ev;

  uart_mmio_top u_uart_mmio_top (
    .clk       (clk),
    .rst_n     (rst_n),
    .axil_req  (axil_req),
    .axil_rsp  (axil_rsp),
    .serial_rx (serial_line),
    .serial_tx (serial_line)
  );

  always #20 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Calling process stalls here while the abort process ends the run
  task automatic abort_run(input string why);
    $display("%s", why);
    -> abort_ev;
    @(abort_ev);
  endtask

  initial begin : abort_on_timeout
    @(abort_ev);
    $display("Test failures found");
    $finish;
  end

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      $display("FAILED %s: got 0x%08h, expected 0x%08h", name, actual, expected);
      errors++;
    end
  endtask

  task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
                           output logic [1:0] resp);
    int waited;
    waited = 0;
    @(posedge clk);
    #2;
    axil_req.awvalid = 1'b1;
    axil_req.awaddr  = addr;
    axil_req.wvalid  = 1'b1;
    axil_req.wdata   = data;
    axil_req.wstrb   = 4'hF;
    do begin
      @(negedge clk);
      waited++;
    end while (!(axil_rsp.awready && axil_rsp.wready) && waited < HANDSHAKE_LIMIT);
    if (!(axil_rsp.awready && axil_rsp.wready)) begin
      abort_run("Timed out waiting for awready and wready on the write channels");
    end
    @(posedge clk);  // Address and data handshake
    #2;
    axil_req.awvalid = 1'b0;
    axil_req.wvalid  = 1'b0;
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (!axil_rsp.bvalid && waited < HANDSHAKE_LIMIT);
    if (!axil_rsp.bvalid) abort_run("Timed out waiting for bvalid on the write response");
    resp = axil_rsp.bresp;
    @(posedge clk);  // Response waits one cycle for bready
    #2;
    axil_req.bready = 1'b1;
    @(posedge clk);
    #2;
    axil_req.bready = 1'b0;
  endtask

  task automatic axi_read(input logic [7:0] addr, output logic [31:0] data,
                          output logic [1:0] resp);
    int waited;
    waited = 0;
    @(posedge clk);
    #2;
    axil_req.arvalid = 1'b1;
    axil_req.araddr  = addr;
    do begin
      @(negedge clk);
      waited++;
    end while (!axil_rsp.arready && waited < HANDSHAKE_LIMIT);
    if (!axil_rsp.arready) abort_run("Timed out waiting for arready on the read channel");
    @(posedge clk);
    #2;
    axil_req.arvalid = 1'b0;
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (!axil_rsp.rvalid && waited < HANDSHAKE_LIMIT);
    if (!axil_rsp.rvalid) abort_run("Timed out waiting for rvalid on the read data channel");
    data = axil_rsp.rdata;
    resp = axil_rsp.rresp;
    @(posedge clk);  // Data waits one cycle for rready
    #2;
    axil_req.rready = 1'b1;
    @(posedge clk);
    #2;
    axil_req.rready = 1'b0;
  endtask

  // Poll the status word until the given flag is set
  task automatic wait_status_bit(input int flag, input string flag_name);
    logic [31:0] status;
    logic [1:0]  resp;
    int          polls;
    polls = 0;
    do begin
      axi_read(REG_STATUS, status, resp);
      polls++;
    end while (!status[flag] && polls < POLL_LIMIT);
    if (!status[flag]) begin
      abort_run($sformatf("Timed out polling the status register for %s", flag_name));
    end
    @(posedge clk);
  endtask

  task automatic check_loopback(input uart_byte_t expected);
    logic [31:0] data;
    logic [1:0]  resp;
    wait_status_bit(1, "rx_valid");
    axi_read(REG_RX_DATA, data, resp);
    check_value("rx_data rdata", data, {24'h0, expected});
    check_value("rx_data rresp", resp, RESP_OKAY);
    if (decoded_q.size() == 0) begin
      $display("No byte was decoded from serial_tx before the RX read");
      errors++;
    end else begin
      check_value("serial_tx byte", decoded_q.pop_front(), expected);
    end
  endtask

  // Independent 8N1 decoder, samples at negedge near mid-bit
  always begin : serial_decode
    uart_byte_t rx_byte;
    @(negedge clk);
    if (rst_n && !serial_line) begin
      repeat (CLKS_PER_BIT / 2) @(negedge clk);
      for (int i = 0; i < 8; i++) begin
        repeat (CLKS_PER_BIT) @(negedge clk);
        rx_byte[i] = serial_line;
      end
      repeat (CLKS_PER_BIT) @(negedge clk);
      if (!serial_line) begin
        $display("Stop bit on serial_tx was low");
        errors++;
      end
      decoded_q.push_back(rx_byte);
    end
  end

  initial begin
    logic [31:0] rd_data;
    logic [31:0] cyc_first;
    logic [31:0] rnd;
    logic [1:0]  resp;
    uart_byte_t  rnd_bytes [4];
    int          total;
    clk      = 1'b0;
    rst_n    = 1'b0;
    axil_req = '0;
    errors   = 0;
    checks   = 0;
    repeat (3) @(posedge clk);
    #2 rst_n = 1'b1;

    axi_read(REG_STATUS, rd_data, resp);
    check_value("status rdata", rd_data, 32'h1);  // tx_ready only
    check_value("status rresp", resp, RESP_OKAY);
    axi_read(REG_RX_DATA, rd_data, resp);
    check_value("empty rx_data rdata", rd_data, 32'h0);
    check_value("empty rx_data rresp", resp, RESP_OKAY);

    for (int i = 0; i < 8; i++) begin
      axi_write(REG_TX_DATA, {24'h0, LOOP_TABLE[i].send}, resp);
      check_value("tx_data bresp", resp, RESP_OKAY);
      check_loopback(LOOP_TABLE[i].expect_rx);
      axi_read(REG_STATUS, rd_data, resp);
      check_value("status rx_valid", rd_data[1], 1'b0);
    end

    // Burst of random bytes, returned in write order
    rnd = 32'h196a;
    for (int i = 0; i < 4; i++) begin
      rnd = xorshift32(rnd);
      rnd_bytes[i] = rnd[7:0];
      axi_write(REG_TX_DATA, {24'h0, rnd_bytes[i]}, resp);
      check_value("tx_data bresp", resp, RESP_OKAY);
    end
    for (int i = 0; i < 4; i++) begin
      check_loopback(rnd_bytes[i]);
    end
    axi_read(REG_STATUS, rd_data, resp);
    check_value("status rx_valid after burst", rd_data[1], 1'b0);

    axi_read(REG_CYCLES, cyc_first, resp);
    check_value("cycles rresp", resp, RESP_OKAY);
    repeat (IDLE_GAP) @(posedge clk);
    axi_read(REG_CYCLES, rd_data, resp);
    check_value("cycle delta at least gap", (rd_data - cyc_first) >= IDLE_GAP, 1'b1);
    axi_write(REG_CNT_RST, 32'h0, resp);
    check_value("cnt_rst bresp", resp, RESP_OKAY);
    axi_read(REG_CYCLES, rd_data, resp);
    check_value("cycles below 16 after clear", rd_data < 16, 1'b1);

    axi_write(REG_STATUS, 32'h3, resp);
    check_value("status write bresp", resp, RESP_SLVERR);
    axi_read(8'h1C, rd_data, resp);
    check_value("unmapped rdata", rd_data, 32'h0);
    check_value("unmapped rresp", resp, RESP_SLVERR);
    axi_write(8'h1C, 32'hDEAD_BEEF, resp);
    check_value("unmapped bresp", resp, RESP_SLVERR);

    // Writes beyond a full TX FIFO are dropped but still answered OKAY
    for (int i = 0; i < FILL_WRITES; i++) begin
      axi_write(REG_TX_DATA, {24'h0, 8'(i)}, resp);
      check_value("tx_data bresp while filling", resp, RESP_OKAY);
    end
    axi_read(REG_STATUS, rd_data, resp);
    check_value("status tx_ready when full", rd_data[0], 1'b0);
    wait_status_bit(0, "tx_ready");

    total = errors + int'(u_uart_mmio_top.u_chk.fail_cnt);
    $display("Checks: %0d, errors: %0d, assertion failures: %0d", checks, errors,
             u_uart_mmio_top.u_chk.fail_cnt);
    if (total == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

//--- vlog.f
logic/uart_mmio_pkg.sv
logic/uart_bit_timer.sv
logic/byte_fifo.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/axil_mmio_fsm.sv
logic/uart_mmio_top.sv
verif/uart_mmio_chk.sv
verif/tb_uart_mmio.sv

//--- run.sh
#!/bin/sh
# Build and run the UART MMIO testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_uart_mmio -Mdir obj_dir -f vlog.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/Vtb_uart_mmio)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx 'All tests passed!'; then
  exit 0
fi
exit 1
